// File: flist.f
matrix_pkg.sv
fb_write_if.sv
cmd_decoder.sv
framebuffer.sv
scan_engine.sv
pixel_output.sv
led_matrix_top.sv
tb_led_matrix.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --top-module tb_led_matrix \
	-f flist.f -o sim_led_matrix; then
	echo "build failed"
	exit 1
fi

output=$(./obj_dir/sim_led_matrix 2>&1)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "SIMULATION PASSED"; then
	exit 0
fi
echo "pass message not found in simulation output"
exit 1

// File: tb_led_matrix.sv
// self-checking testbench that loads the led matrix core and checks whole scanned frames
`timescale 1ns/1ps

module tb_led_matrix;
	import matrix_pkg::*;

	localparam int PIXEL_DIV = 4;
	localparam int OE_UNIT = 2;
	localparam int NUM_STEPS = 5;
	// latches in one frame
	localparam int FRAME_LATCHES = HALF_ROWS * NUM_PLANES;
	localparam int FRAME_LIMIT = 20000;
	localparam int STEP_LIMIT = 200;

	logic clk_root;
	logic arst_n;
	logic rx_valid;
	logic [7:0] rx_data;
	logic [2:0] row_addr;
	logic clk_pixel;
	logic latch;
	logic oe_n;
	logic [2:0] rgb_top;
	logic [2:0] rgb_bottom;
	logic [7:0] cmd_count;

	// reference state of the panel
	logic [15:0] model_fb [NUM_ROWS][MATRIX_COLS];
	logic [2:0] model_rgb_en;
	logic [5:0] model_bright_en;
	logic [7:0] model_count;
	logic [31:0] rng_state;
	int latch_count;

	// step table with the junk byte sent ahead of the enable commands
	string step_name [NUM_STEPS] = '{"red_off", "green_only", "odd_planes_off",
		"blue_low_planes", "all_dark"};
	logic [7:0] junk_op [NUM_STEPS] = '{8'h5A, 8'h00, 8'hFF, 8'h6C, 8'h62};
	logic [7:0] rgb_arg [NUM_STEPS] = '{8'h03, 8'hF2, 8'h07, 8'h01, 8'h05};
	logic [7:0] bright_arg [NUM_STEPS] = '{8'h3F, 8'h3F, 8'h15, 8'hC7, 8'h00};

	led_matrix_top #(
		.PIXEL_DIV(PIXEL_DIV),
		.OE_UNIT(OE_UNIT)
	) dut (
		.clk_root(clk_root),
		.arst_n(arst_n),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.row_addr(row_addr),
		.clk_pixel(clk_pixel),
		.latch(latch),
		.oe_n(oe_n),
		.rgb_top(rgb_top),
		.rgb_bottom(rgb_bottom),
		.cmd_count(cmd_count)
	);

	initial begin
		clk_root = 1'b0;
		forever #2 clk_root = ~clk_root;
	end

	task stop_with_failure(input string why);
		$display("%s", why);
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual) begin
			$display("FAIL %s expected %0h actual %0h", name, expected, actual);
			stop_with_failure("value mismatch");
		end
	endtask

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// rgb565 bit-plane rule with red and blue one plane behind green
	function automatic logic [2:0] expected_bits(input logic [15:0] w, input int p);
		logic r;
		logic g;
		logic b;
		g = w[5 + p];
		r = (p == 0) ? 1'b0 : w[10 + p];
		b = (p == 0) ? 1'b0 : w[p - 1];
		if (!model_bright_en[p])
			return 3'b000;
		return {r, g, b} & model_rgb_en;
	endfunction

	// latch counter and overlap watch
	always @(negedge clk_root) begin
		if (!arst_n) begin
			latch_count <= 0;
		end else begin
			if (latch)
				latch_count <= latch_count + 1;
			if (latch && !oe_n)
				stop_with_failure("latch and output enable were active in the same cycle");
		end
	end

	// one strobe after a random gap of 0 to 2 cycles
	task automatic send_byte(input logic [7:0] b);
		int gap;
		gap = int'(lcg_next() % 32'd3);
		repeat (gap) @(negedge clk_root);
		rx_valid = 1'b1;
		rx_data = b;
		@(negedge clk_root);
		rx_valid = 1'b0;
	endtask

	task automatic load_row(input int r);
		logic [15:0] w;
		send_byte(OP_LOAD_ROW);
		send_byte(8'(r));
		for (int c = 0; c < MATRIX_COLS; c++) begin
			w = 16'(lcg_next() >> 16);
			model_fb[r][c] = w;
			// high byte first
			send_byte(w[15:8]);
			send_byte(w[7:0]);
		end
	endtask

	task automatic wait_pixel_rise();
		logic prev;
		int n;
		prev = clk_pixel;
		n = 0;
		forever begin
			@(negedge clk_root);
			n++;
			if (clk_pixel && !prev)
				break;
			prev = clk_pixel;
			if (n > STEP_LIMIT)
				stop_with_failure("timeout waiting for a pixel clock rise");
		end
	endtask

	task automatic wait_latch();
		int n;
		n = 0;
		while (!latch) begin
			@(negedge clk_root);
			n++;
			if (n > STEP_LIMIT)
				stop_with_failure("timeout waiting for a latch pulse");
		end
	endtask

	// cycles with oe_n low after the latch
	task automatic measure_oe_low(output int len);
		int n;
		n = 0;
		while (oe_n) begin
			@(negedge clk_root);
			n++;
			if (n > STEP_LIMIT)
				stop_with_failure("timeout waiting for output enable to go low");
		end
		len = 0;
		while (!oe_n) begin
			len++;
			@(negedge clk_root);
			if (len > STEP_LIMIT)
				stop_with_failure("output enable stayed low too long");
		end
	endtask

	task automatic check_frame(input string name);
		int start;
		int n;
		int len;
		int len0;
		string tag;
		start = latch_count;
		n = 0;
		len0 = 0;
		// sync to the latch of row 7 plane 5
		while (latch_count == start || latch_count % FRAME_LATCHES != 0) begin
			@(negedge clk_root);
			n++;
			if (n > FRAME_LIMIT)
				stop_with_failure("timeout waiting for the start of a frame");
		end
		for (int r = 0; r < HALF_ROWS; r++) begin
			for (int p = 0; p < NUM_PLANES; p++) begin
				for (int c = 0; c < MATRIX_COLS; c++) begin
					wait_pixel_rise();
					tag = $sformatf("%s r%0d p%0d c%0d", name, r, p, c);
					check_value({tag, " top"}, 32'(expected_bits(model_fb[r][c], p)),
						32'(rgb_top));
					check_value({tag, " bottom"},
						32'(expected_bits(model_fb[r + HALF_ROWS][c], p)), 32'(rgb_bottom));
				end
				wait_latch();
				tag = $sformatf("%s r%0d p%0d", name, r, p);
				check_value({tag, " row_addr"}, 32'(r), 32'(row_addr));
				measure_oe_low(len);
				if (p == 0) begin
					len0 = len;
					check_value({tag, " oe plane 0"}, 32'(OE_UNIT), 32'(len));
				end else begin
					// binary weighted display time
					check_value({tag, " oe weight"}, 32'(len0 << p), 32'(len));
				end
			end
		end
	endtask

	initial begin
		rng_state = 32'h2783_0f73;
		rx_valid = 1'b0;
		rx_data = 8'h00;
		arst_n = 1'b0;
		model_rgb_en = 3'b111;
		model_bright_en = 6'h3F;
		model_count = 8'd0;
		repeat (5) @(negedge clk_root);
		// idle outputs while still in reset
		check_value("reset oe_n", 32'(1), 32'(oe_n));
		check_value("reset latch", 32'(0), 32'(latch));
		check_value("reset cmd_count", 32'(0), 32'(cmd_count));
		check_value("reset rgb_top", 32'(0), 32'(rgb_top));
		check_value("reset rgb_bottom", 32'(0), 32'(rgb_bottom));
		arst_n = 1'b1;
		for (int r = 0; r < NUM_ROWS; r++)
			load_row(r);
		model_count = 8'd16;
		check_value("load cmd_count", 32'(model_count), 32'(cmd_count));
		check_frame("full_frame");
		for (int s = 0; s < NUM_STEPS; s++) begin
			send_byte(junk_op[s]);
			check_value({step_name[s], " junk cmd_count"}, 32'(model_count), 32'(cmd_count));
			send_byte(OP_RGB_EN);
			send_byte(rgb_arg[s]);
			send_byte(OP_BRIGHT_EN);
			send_byte(bright_arg[s]);
			model_rgb_en = rgb_arg[s][2:0];
			model_bright_en = bright_arg[s][5:0];
			model_count = model_count + 8'd2;
			check_value({step_name[s], " cmd_count"}, 32'(model_count), 32'(cmd_count));
			check_frame(step_name[s]);
		end
		$display("SIMULATION PASSED");
		$finish;
	end

endmodule

// File: led_matrix_top.sv
// top of the hub75 panel driver core, byte commands in and panel signals out
`timescale 1ns/1ps

module led_matrix_top #(
	parameter int PIXEL_DIV = 4,
	parameter int OE_UNIT = 2
) (
	input logic clk_root,
	input logic arst_n,
	input logic rx_valid,
	input logic [7:0] rx_data,
	output logic [2:0] row_addr,
	output logic clk_pixel,
	output logic latch,
	output logic oe_n,
	output logic [2:0] rgb_top,
	output logic [2:0] rgb_bottom,
	output logic [7:0] cmd_count
);
	import matrix_pkg::*;

	// decoder to memory
	fb_write_if fb_wr ();

	// settings to output stage
	logic [2:0] rgb_enable;
	logic [5:0] bright_enable;
	// scan read path
	logic [2:0] rd_row;
	fb_col_t rd_col;
	pixel_u pix_top;
	pixel_u pix_bottom;
	logic [2:0] plane;
	logic load_strobe;

	cmd_decoder u_cmd_decoder (
		.clk_root(clk_root),
		.arst_n(arst_n),
		.rx_valid(rx_valid),
		.rx_data(rx_data),
		.fb_wr(fb_wr.source),
		.rgb_enable(rgb_enable),
		.bright_enable(bright_enable),
		.cmd_count(cmd_count)
	);

	framebuffer u_framebuffer (
		.clk_root(clk_root),
		.fb_wr(fb_wr.sink),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.pix_top(pix_top),
		.pix_bottom(pix_bottom)
	);

	scan_engine #(
		.PIXEL_DIV(PIXEL_DIV),
		.OE_UNIT(OE_UNIT)
	) u_scan_engine (
		.clk_root(clk_root),
		.arst_n(arst_n),
		.rd_row(rd_row),
		.rd_col(rd_col),
		.plane(plane),
		.load_strobe(load_strobe),
		.clk_pixel(clk_pixel),
		.latch(latch),
		.oe_n(oe_n),
		.row_addr(row_addr)
	);

	pixel_output u_pixel_output (
		.clk_root(clk_root),
		.arst_n(arst_n),
		.pix_top(pix_top),
		.pix_bottom(pix_bottom),
		.plane(plane),
		.load_strobe(load_strobe),
		.rgb_enable(rgb_enable),
		.bright_enable(bright_enable),
		.rgb_top(rgb_top),
		.rgb_bottom(rgb_bottom)
	);

endmodule

// File: pixel_output.sv
// picks the current plane bit from both pixels, applies the enables and drives the colour lines
`timescale 1ns/1ps

module pixel_output (
	input logic clk_root,
	input logic arst_n,
	input matrix_pkg::pixel_u pix_top,
	input matrix_pkg::pixel_u pix_bottom,
	input logic [2:0] plane,
	input logic load_strobe,
	input logic [2:0] rgb_enable,
	input logic [5:0] bright_enable,
	output logic [2:0] rgb_top,
	output logic [2:0] rgb_bottom
);
	import matrix_pkg::*;

	logic [5:0] bright_sh;
	logic plane_on;
	logic [2:0] bits_top;
	logic [2:0] bits_bottom;

	// {red, green, blue} for plane p, 5-bit channels lag green by one plane
	function automatic logic [2:0] plane_bits(input pixel_u px, input logic [2:0] p);
		logic [2:0] p_lo;
		logic [4:0] red_sh;
		logic [5:0] green_sh;
		logic [4:0] blue_sh;
		p_lo = p - 3'd1;
		red_sh = px.field.red >> p_lo;
		green_sh = px.field.green >> p;
		blue_sh = px.field.blue >> p_lo;
		if (p == 3'd0)
			return {1'b0, green_sh[0], 1'b0};
		return {red_sh[0], green_sh[0], blue_sh[0]};
	endfunction

	// brightness enable bit of this plane
	assign bright_sh = bright_enable >> plane;
	assign plane_on = bright_sh[0];

	assign bits_top = plane_bits(pix_top, plane) & rgb_enable & {3{plane_on}};
	assign bits_bottom = plane_bits(pix_bottom, plane) & rgb_enable & {3{plane_on}};

	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			rgb_top <= 3'b000;
			rgb_bottom <= 3'b000;
		end else if (load_strobe) begin
			rgb_top <= bits_top;
			rgb_bottom <= bits_bottom;
		end
	end

	// scan engine only loads for real planes
	a_plane_range: assert property (@(posedge clk_root) disable iff (!arst_n)
		load_strobe |-> plane < 3'(NUM_PLANES));

endmodule

// File: scan_engine.sv
// walks rows, bit planes and columns, and times the panel shift clock, latch and weighted enable
`timescale 1ns/1ps

module scan_engine #(
	parameter int PIXEL_DIV = 4,
	parameter int OE_UNIT = 2
) (
	input logic clk_root,
	input logic arst_n,
	output logic [2:0] rd_row,
	output matrix_pkg::fb_col_t rd_col,
	output logic [2:0] plane,
	output logic load_strobe,
	output logic clk_pixel,
	output logic latch,
	output logic oe_n,
	output logic [2:0] row_addr
);
	import matrix_pkg::*;

	localparam int SLOT_W = $clog2(PIXEL_DIV);
	// longest display time, top plane
	localparam int OE_MAX = OE_UNIT << (NUM_PLANES - 1);
	localparam int OE_W = $clog2(OE_MAX + 1);

	localparam logic [1:0] PH_SHIFT = 2'd0;
	localparam logic [1:0] PH_LATCH = 2'd1;
	localparam logic [1:0] PH_DISPLAY = 2'd2;

	logic [1:0] phase;
	logic [SLOT_W-1:0] slot;
	fb_col_t col;
	logic [2:0] row;
	logic [OE_W-1:0] oe_cnt;
	logic slot_last;
	logic col_last;
	logic plane_last;

	assign slot_last = (slot == SLOT_W'(PIXEL_DIV - 1));
	assign col_last = (col == fb_col_t'(MATRIX_COLS - 1));
	assign plane_last = (plane == 3'(NUM_PLANES - 1));

	// read address straight from the counters, issued in slot 0
	assign rd_row = row;
	assign rd_col = col;

	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			phase <= PH_SHIFT;
			slot <= '0;
			col <= '0;
			plane <= 3'd0;
			row <= 3'd0;
			row_addr <= 3'd0;
			latch <= 1'b0;
			oe_n <= 1'b1;
			oe_cnt <= '0;
		end else begin
			case (phase)
				PH_SHIFT: begin
					if (slot_last) begin
						slot <= '0;
						col <= col + 1'b1;
						// whole row of this plane shifted out
						if (col_last) begin
							latch <= 1'b1;
							row_addr <= row;
							phase <= PH_LATCH;
						end
					end else begin
						slot <= slot + 1'b1;
					end
				end
				PH_LATCH: begin
					latch <= 1'b0;
					oe_n <= 1'b0;
					// binary weight of the plane
					oe_cnt <= OE_W'(OE_UNIT) << plane;
					phase <= PH_DISPLAY;
				end
				PH_DISPLAY: begin
					if (oe_cnt == OE_W'(1)) begin
						oe_n <= 1'b1;
						phase <= PH_SHIFT;
						// next plane, or next row after the top plane
						if (plane_last) begin
							plane <= 3'd0;
							row <= row + 1'b1;
						end else begin
							plane <= plane + 1'b1;
						end
					end else begin
						oe_cnt <= oe_cnt - 1'b1;
					end
				end
				default: phase <= PH_SHIFT;
			endcase
		end
	end

	// load in slot 1, clock high from slot 2 to the end of the slot
	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			load_strobe <= 1'b0;
			clk_pixel <= 1'b0;
		end else begin
			load_strobe <= (phase == PH_SHIFT) && (slot == '0);
			clk_pixel <= (phase == PH_SHIFT) && (slot != '0) && !slot_last;
		end
	end

	// panel must not glow while the new row is latched
	a_latch_oe_apart: assert property (@(posedge clk_root) disable iff (!arst_n)
		!(latch && !oe_n));

	// no shift clock pulses leak into latch or display
	a_clk_in_shift: assert property (@(posedge clk_root) disable iff (!arst_n)
		clk_pixel |-> phase == PH_SHIFT);

endmodule

// File: framebuffer.sv
// dual-bank pixel store, written by the decoder and read one column of both halves at a time
`timescale 1ns/1ps

module framebuffer (
	input logic clk_root,
	fb_write_if.sink fb_wr,
	input logic [2:0] rd_row,
	input matrix_pkg::fb_col_t rd_col,
	output matrix_pkg::pixel_u pix_top,
	output matrix_pkg::pixel_u pix_bottom
);
	import matrix_pkg::*;

	localparam int BANK_WORDS = HALF_ROWS * MATRIX_COLS;
	localparam int ADDR_W = $clog2(BANK_WORDS);

	// rows 0..7 and rows 8..15
	pixel_u bank_top [BANK_WORDS];
	pixel_u bank_bottom [BANK_WORDS];

	logic [ADDR_W-1:0] wr_addr;
	logic [ADDR_W-1:0] rd_addr;
	logic wr_top;
	logic wr_bottom;

	// row within the half, then column
	assign wr_addr = {fb_wr.wr_row[2:0], fb_wr.wr_col};
	assign rd_addr = {rd_row, rd_col};
	// row bit 3 steers to the bottom bank
	assign wr_top = fb_wr.wr_en && !fb_wr.wr_row[3];
	assign wr_bottom = fb_wr.wr_en && fb_wr.wr_row[3];

	// registered read, old data on a same-address collision
	always_ff @(posedge clk_root) begin
		if (wr_top)
			bank_top[wr_addr] <= fb_wr.wr_pixel;
		if (wr_bottom)
			bank_bottom[wr_addr] <= fb_wr.wr_pixel;
		pix_top <= bank_top[rd_addr];
		pix_bottom <= bank_bottom[rd_addr];
	end

endmodule

// File: cmd_decoder.sv
// turns the received command byte stream into framebuffer writes and display enable settings
`timescale 1ns/1ps

module cmd_decoder (
	input logic clk_root,
	input logic arst_n,
	input logic rx_valid,
	input logic [7:0] rx_data,
	fb_write_if.source fb_wr,
	output logic [2:0] rgb_enable,
	output logic [5:0] bright_enable,
	output logic [7:0] cmd_count
);
	import matrix_pkg::*;

	// fsm encoding
	localparam logic [2:0] ST_OPCODE = 3'd0;
	localparam logic [2:0] ST_ROW = 3'd1;
	localparam logic [2:0] ST_PIX_HI = 3'd2;
	localparam logic [2:0] ST_PIX_LO = 3'd3;
	localparam logic [2:0] ST_ARG = 3'd4;

	logic [2:0] state;
	fb_row_t row;
	fb_col_t col;
	logic [7:0] hi_byte;
	// which register the argument byte goes to
	logic arg_bright;
	logic last_col;

	assign last_col = (col == fb_col_t'(MATRIX_COLS - 1));

	// low byte completes the word and the memory takes it on this edge
	assign fb_wr.wr_en = rx_valid && (state == ST_PIX_LO);
	assign fb_wr.wr_row = row;
	assign fb_wr.wr_col = col;
	assign fb_wr.wr_pixel.raw = {hi_byte, rx_data};

	always_ff @(posedge clk_root or negedge arst_n) begin
		if (!arst_n) begin
			state <= ST_OPCODE;
			col <= '0;
			arg_bright <= 1'b0;
			rgb_enable <= 3'b111;
			bright_enable <= 6'h3F;
			cmd_count <= 8'd0;
		end else if (rx_valid) begin
			case (state)
				ST_OPCODE: begin
					// unknown opcodes just fall through
					case (rx_data)
						OP_LOAD_ROW: state <= ST_ROW;
						OP_RGB_EN: begin
							arg_bright <= 1'b0;
							state <= ST_ARG;
						end
						OP_BRIGHT_EN: begin
							arg_bright <= 1'b1;
							state <= ST_ARG;
						end
						default: state <= ST_OPCODE;
					endcase
				end
				ST_ROW: begin
					col <= '0;
					state <= ST_PIX_HI;
				end
				ST_PIX_HI: state <= ST_PIX_LO;
				ST_PIX_LO: begin
					// wraps back to 0 after the last column
					col <= col + 1'b1;
					if (last_col) begin
						cmd_count <= cmd_count + 8'd1;
						state <= ST_OPCODE;
					end else begin
						state <= ST_PIX_HI;
					end
				end
				ST_ARG: begin
					if (arg_bright)
						bright_enable <= rx_data[5:0];
					else
						rgb_enable <= rx_data[2:0];
					cmd_count <= cmd_count + 8'd1;
					state <= ST_OPCODE;
				end
				default: state <= ST_OPCODE;
			endcase
		end
	end

	// row number and high byte of the load in progress
	always_ff @(posedge clk_root) begin
		if (rx_valid && state == ST_ROW)
			row <= rx_data[3:0];
		if (rx_valid && state == ST_PIX_HI)
			hi_byte <= rx_data;
	end

	// after a write the fsm waits for the next high byte at a new column
	// or, once column 31 is written, returns to opcode with the column wrapped
	a_wr_then_next: assert property (@(posedge clk_root) disable iff (!arst_n)
		fb_wr.wr_en |=> (state == ST_PIX_HI && col != '0)
			|| (state == ST_OPCODE && col == '0));

endmodule

// File: fb_write_if.sv
// framebuffer write bundle between the command decoder and the pixel memory
`timescale 1ns/1ps

interface fb_write_if;
	import matrix_pkg::*;

	// one word per cycle with wr_en high, never stalled
	logic wr_en;
	fb_row_t wr_row;
	fb_col_t wr_col;
	pixel_u wr_pixel;

	// decoder side
	modport source (
		output wr_en,
		output wr_row,
		output wr_col,
		output wr_pixel
	);

	// memory side
	modport sink (
		input wr_en,
		input wr_row,
		input wr_col,
		input wr_pixel
	);

endinterface

// File: matrix_pkg.sv
// shared panel geometry, command opcodes and pixel types, imported by every block and the testbench
package matrix_pkg;

	// panel geometry
	localparam int MATRIX_COLS = 32;
	localparam int HALF_ROWS = 8;
	localparam int NUM_ROWS = 16;
	// bcm depth
	localparam int NUM_PLANES = 6;

	// command opcodes, ascii
	localparam logic [7:0] OP_LOAD_ROW = 8'h4C;
	localparam logic [7:0] OP_RGB_EN = 8'h45;
	localparam logic [7:0] OP_BRIGHT_EN = 8'h42;

	// rgb565 word, red in the top bits
	typedef union packed {
		logic [15:0] raw;
		struct packed {
			logic [4:0] red;
			logic [5:0] green;
			logic [4:0] blue;
		} field;
	} pixel_u;

	// bit 3 picks the panel half
	typedef logic [3:0] fb_row_t;
	typedef logic [4:0] fb_col_t;

endpackage
